// ==== design/probe_params.svh ====
// stream probe parameters
`ifndef PROBE_PARAMS_SVH
`define PROBE_PARAMS_SVH

// stream and counter widths
`define DATA_BYTES 8
`define PKT_CNT_W  50
`define BYTE_CNT_W 56
`define REG_ADDR_W 4

// register map, 32-bit words
`define REG_CONTROL      4'd0
`define REG_GOOD_PKT_LO  4'd1
`define REG_GOOD_PKT_HI  4'd2
`define REG_GOOD_BYTE_LO 4'd3
`define REG_GOOD_BYTE_HI 4'd4
`define REG_ERR_PKT_LO   4'd5
`define REG_ERR_PKT_HI   4'd6
`define REG_ERR_BYTE_LO  4'd7
`define REG_ERR_BYTE_HI  4'd8
`define REG_MONITOR      4'd9
`define REG_ACTIVITY     4'd10
`endif

// ==== design/probe_pkg.sv ====
// stream probe types
`include "probe_params.svh"

package probe_pkg;

   // one observed beat of the stream, sampled every cycle
   typedef struct packed {
      logic                   aresetn;
      logic                   tvalid;
      logic                   tready;
      logic [`DATA_BYTES-1:0] tkeep;
      logic                   tlast;
      logic                   tuser;  // packet error flag on the tlast beat
   } axi4s_beat_t;

   // live or latched statistics of one probe mode
   typedef struct packed {
      logic [`PKT_CNT_W-1:0]  pkts;
      logic [`BYTE_CNT_W-1:0] bytes;
   } probe_counts_t;

   // handshake levels, shared by monitor and activity
   typedef struct packed {
      logic aresetn;
      logic tvalid;
      logic tready;
      logic tlast;
   } line_status_t;

   // what a counter instance keeps
   typedef enum logic [1:0] {
      GOOD   = 2'd0,
      OVFL   = 2'd1,  // refused beats, no counter built for it
      ERRORS = 2'd2
   } probe_mode_t;

endpackage

// ==== design/stream_counter.sv ====
// packet and byte counter
`timescale 1ns/1ps
`include "probe_params.svh"

module stream_counter #(
   parameter probe_pkg::probe_mode_t MODE = probe_pkg::GOOD
) (
   input  logic                     axi4s_if,
   input  logic                     reset,
   input  probe_pkg::axi4s_beat_t   beat,
   input  logic                     clear,
   output probe_pkg::probe_counts_t counts
);
   import probe_pkg::*;

   localparam int ONES_W = $clog2(`DATA_BYTES) + 1;
   localparam int ACC_W  = 16;  // bytes of one packet
   localparam int BYTE_W = `BYTE_CNT_W;

   // number of valid bytes in one beat
   function automatic logic [ONES_W-1:0] count_ones(input logic [`DATA_BYTES-1:0] keep);
      logic [ONES_W-1:0] n;
      n = '0;
      for (int i = 0; i < `DATA_BYTES; i++) begin
         n = n + ONES_W'(keep[i]);
      end
      return n;
   endfunction

   // stage 0 holds a registered copy of the stream
   axi4s_beat_t beat_q;

   // stage 1
   logic              fire_s1;  // beat accepted
   logic              last_s1;  // accepted tlast beat
   logic              err_s1;   // tuser on that tlast beat
   logic [ONES_W-1:0] ones_s1;

   // stage 2
   logic [ACC_W-1:0]  acc;           // running bytes of the open packet
   logic              pkt_end_s2;    // packet to be added
   logic [ACC_W-1:0]  pkt_bytes_s2;
   logic              keep_pkt;

   always_ff @(posedge axi4s_if) begin
      beat_q <= beat;
   end

   always_ff @(posedge axi4s_if) begin
      if (reset) begin
         fire_s1 <= 1'b0;
         last_s1 <= 1'b0;
      end else begin
         fire_s1 <= beat_q.tvalid && beat_q.tready;
         last_s1 <= beat_q.tvalid && beat_q.tready && beat_q.tlast;
      end
   end

   always_ff @(posedge axi4s_if) begin
      err_s1  <= beat_q.tuser;
      ones_s1 <= count_ones(beat_q.tkeep);
   end

   // good mode drops errored packets and errors mode drops the rest
   always_comb begin
      if (MODE == ERRORS) begin
         keep_pkt = err_s1;
      end else begin
         keep_pkt = !err_s1;
      end
   end

   always_ff @(posedge axi4s_if) begin
      if (reset) begin
         acc        <= '0;
         pkt_end_s2 <= 1'b0;
      end else begin
         pkt_end_s2 <= last_s1 && keep_pkt;
         if (last_s1) begin
            acc <= '0;  // next packet starts empty
         end else if (fire_s1) begin
            acc <= acc + ACC_W'(ones_s1);
         end
      end
   end

   // total of the closing packet with its tlast beat
   always_ff @(posedge axi4s_if) begin
      if (last_s1) begin
         pkt_bytes_s2 <= acc + ACC_W'(ones_s1);
      end
   end

   // stage 3 holds the live counts
   always_ff @(posedge axi4s_if) begin
      if (reset || clear) begin
         counts <= '0;  // a packet ending now is dropped
      end else if (pkt_end_s2) begin
         counts.pkts  <= counts.pkts + 1'b1;
         counts.bytes <= counts.bytes + BYTE_W'(pkt_bytes_s2);
      end
   end

   // counts only move backwards through clear or reset
   pkts_monotonic : assert property (
      @(posedge axi4s_if) disable iff (reset)
      (!$past(clear) && !$past(reset)) |-> (counts.pkts >= $past(counts.pkts))
   ) else $error("packet count decreased without a clear");

endmodule

// ==== design/probe_regmap.sv ====
// probe register map
`timescale 1ns/1ps
`include "probe_params.svh"

module probe_regmap (
   input  logic                     axi4s_if,
   input  logic                     reset,
   input  probe_pkg::axi4s_beat_t   beat,
   input  probe_pkg::probe_counts_t good_counts,
   input  probe_pkg::probe_counts_t err_counts,
   input  logic                     reg_wr,
   input  logic                     reg_rd,
   input  logic [`REG_ADDR_W-1:0]   reg_addr,
   input  logic [31:0]              reg_wdata,
   output logic [31:0]              reg_rdata,
   output logic                     reg_rvalid,
   output logic                     clear
);
   import probe_pkg::*;

   localparam int STAT_PAD = 32 - $bits(line_status_t);

   logic          ctrl_wr;   // any write to control
   logic          act_rd;    // read of activity
   logic          latch_q;   // counts frozen between control writes
   logic          snap_en;
   probe_counts_t good_snap;
   probe_counts_t err_snap;
   line_status_t  status_q;  // monitor one cycle behind the stream
   line_status_t  activity;
   logic [31:0]   rdata_nxt;

   assign ctrl_wr = reg_wr && (reg_addr == `REG_CONTROL);
   assign act_rd  = reg_rd && (reg_addr == `REG_ACTIVITY);

   // control bit 0 pulses clear and bit 1 sets latch mode
   always_ff @(posedge axi4s_if) begin
      if (reset) begin
         latch_q <= 1'b0;
         clear   <= 1'b0;
      end else begin
         clear <= ctrl_wr && reg_wdata[0];
         if (ctrl_wr) begin
            latch_q <= reg_wdata[1];
         end
      end
   end

   // snapshots follow live counts unless latched and refresh on any control write
   assign snap_en = !latch_q || ctrl_wr;

   always_ff @(posedge axi4s_if) begin
      if (snap_en) begin
         good_snap <= good_counts;
         err_snap  <= err_counts;
      end
   end

   always_ff @(posedge axi4s_if) begin
      status_q.aresetn <= beat.aresetn;
      status_q.tvalid  <= beat.tvalid;
      status_q.tready  <= beat.tready;
      status_q.tlast   <= beat.tlast;
   end

   // sticky bits where the aresetn bit records a stream reset
   always_ff @(posedge axi4s_if) begin
      if (reset || act_rd) begin
         activity <= '0;
      end else begin
         activity.aresetn <= activity.aresetn || !status_q.aresetn;
         activity.tvalid  <= activity.tvalid || status_q.tvalid;
         activity.tready  <= activity.tready || status_q.tready;
         activity.tlast   <= activity.tlast || status_q.tlast;
      end
   end

   always_comb begin
      case (reg_addr)
         `REG_CONTROL:      rdata_nxt = {30'd0, latch_q, 1'b0};  // clear reads back 0
         `REG_GOOD_PKT_LO:  rdata_nxt = good_snap.pkts[31:0];
         `REG_GOOD_PKT_HI:  rdata_nxt = 32'(good_snap.pkts[`PKT_CNT_W-1:32]);
         `REG_GOOD_BYTE_LO: rdata_nxt = good_snap.bytes[31:0];
         `REG_GOOD_BYTE_HI: rdata_nxt = 32'(good_snap.bytes[`BYTE_CNT_W-1:32]);
         `REG_ERR_PKT_LO:   rdata_nxt = err_snap.pkts[31:0];
         `REG_ERR_PKT_HI:   rdata_nxt = 32'(err_snap.pkts[`PKT_CNT_W-1:32]);
         `REG_ERR_BYTE_LO:  rdata_nxt = err_snap.bytes[31:0];
         `REG_ERR_BYTE_HI:  rdata_nxt = 32'(err_snap.bytes[`BYTE_CNT_W-1:32]);
         `REG_MONITOR:      rdata_nxt = {{STAT_PAD{1'b0}}, status_q};
         `REG_ACTIVITY:     rdata_nxt = {{STAT_PAD{1'b0}}, activity};
         default:           rdata_nxt = '0;
      endcase
   end

   // read data one cycle after the strobe
   always_ff @(posedge axi4s_if) begin
      if (reg_rd) begin
         reg_rdata <= rdata_nxt;
      end
   end

   always_ff @(posedge axi4s_if) begin
      if (reset) begin
         reg_rvalid <= 1'b0;
      end else begin
         reg_rvalid <= reg_rd;
      end
   end

   // every read strobe gets known data on the next cycle
   rvalid_after_rd : assert property (
      @(posedge axi4s_if) disable iff (reset)
      reg_rd |=> (reg_rvalid && !$isunknown(reg_rdata))
   ) else $error("read strobe without a valid response");

endmodule

// ==== design/stream_probe_top.sv ====
// stream probe top level
`timescale 1ns/1ps
`include "probe_params.svh"

module stream_probe_top (
   input  logic                   axi4s_if,
   input  logic                   reset,
   input  probe_pkg::axi4s_beat_t beat,
   input  logic                   reg_wr,
   input  logic                   reg_rd,
   input  logic [`REG_ADDR_W-1:0] reg_addr,
   input  logic [31:0]            reg_wdata,
   output logic [31:0]            reg_rdata,
   output logic                   reg_rvalid
);
   import probe_pkg::*;

   probe_counts_t good_counts;
   probe_counts_t err_counts;
   logic          clear;  // from control write, to both counters

   // packets without tuser on tlast
   stream_counter #(
      .MODE (GOOD)
   ) u_good_counter (
      .axi4s_if (axi4s_if),
      .reset    (reset),
      .beat     (beat),
      .clear    (clear),
      .counts   (good_counts)
   );

   // packets flagged by tuser on tlast
   stream_counter #(
      .MODE (ERRORS)
   ) u_err_counter (
      .axi4s_if (axi4s_if),
      .reset    (reset),
      .beat     (beat),
      .clear    (clear),
      .counts   (err_counts)
   );

   probe_regmap u_probe_regmap (
      .axi4s_if    (axi4s_if),
      .reset       (reset),
      .beat        (beat),
      .good_counts (good_counts),
      .err_counts  (err_counts),
      .reg_wr      (reg_wr),
      .reg_rd      (reg_rd),
      .reg_addr    (reg_addr),
      .reg_wdata   (reg_wdata),
      .reg_rdata   (reg_rdata),
      .reg_rvalid  (reg_rvalid),
      .clear       (clear)
   );

endmodule

// ==== tb/probe_tb.sv ====
// stream probe testbench
`timescale 1ns/1ps
`include "probe_params.svh"

module probe_tb;
   import probe_pkg::*;

   localparam int TIMEOUT = 20;  // cycles allowed for a read response

   logic                   axi4s_if;
   logic                   reset;
   axi4s_beat_t            beat;
   logic                   reg_wr;
   logic                   reg_rd;
   logic [`REG_ADDR_W-1:0] reg_addr;
   logic [31:0]            reg_wdata;
   logic [31:0]            reg_rdata;
   logic                   reg_rvalid;

   axi4s_beat_t idle_beat;  // aresetn high and everything else low
   int          fd;
   int          line_no;

   stream_probe_top u_stream_probe_top (
      .axi4s_if   (axi4s_if),
      .reset      (reset),
      .beat       (beat),
      .reg_wr     (reg_wr),
      .reg_rd     (reg_rd),
      .reg_addr   (reg_addr),
      .reg_wdata  (reg_wdata),
      .reg_rdata  (reg_rdata),
      .reg_rvalid (reg_rvalid)
   );

   initial begin
      axi4s_if = 1'b0;
      forever #5 axi4s_if = ~axi4s_if;
   end

   task automatic stop_run(input string msg);
      $display("%s", msg);
      $display("Finished with errors");
      $fatal(1, "run stopped at first failure");
   endtask

   task automatic report_error(input string msg);
      stop_run($sformatf("error at time %0t: %s", $time, msg));
   endtask

   task automatic check_word(input logic [31:0] got, input logic [31:0] exp, input string what);
      if (got !== exp) begin
         report_error($sformatf("%s read %h, expected %h", what, got, exp));
      end
   endtask

   task automatic check_status(input line_status_t got, input line_status_t exp);
      if (got !== exp) begin
         report_error($sformatf("monitor read %b, expected %b", got, exp));
      end
   endtask

   // one beat held for one cycle
   task automatic drive_beat(input axi4s_beat_t b);
      @(posedge axi4s_if);
      beat <= b;
   endtask

   task automatic idle_cycles(input int n);
      for (int i = 0; i < n; i++) begin
         @(posedge axi4s_if);
         beat <= idle_beat;
      end
   endtask

   task automatic write_reg(input logic [`REG_ADDR_W-1:0] addr, input logic [31:0] data);
      @(posedge axi4s_if);
      beat      <= idle_beat;
      reg_wr    <= 1'b1;
      reg_addr  <= addr;
      reg_wdata <= data;
      @(posedge axi4s_if);
      reg_wr <= 1'b0;
   endtask

   // strobe and then poll the response on falling edges
   task automatic read_reg(input logic [`REG_ADDR_W-1:0] addr, output logic [31:0] data);
      int waited;
      waited = 0;
      @(posedge axi4s_if);
      beat     <= idle_beat;
      reg_rd   <= 1'b1;
      reg_addr <= addr;
      @(posedge axi4s_if);
      reg_rd <= 1'b0;
      @(negedge axi4s_if);
      while (!reg_rvalid && waited < TIMEOUT) begin
         waited++;
         @(negedge axi4s_if);
      end
      if (!reg_rvalid) begin
         stop_run($sformatf("read response never came for address %0h", addr));
      end else begin
         data = reg_rdata;
      end
   endtask

   // one command per line as described in the data file header
   task automatic run_file();
      string        text;
      string        cmd;
      int           fields;
      logic [31:0]  f0;
      logic [31:0]  f1;
      logic [31:0]  f2;
      logic [31:0]  f3;
      logic [31:0]  f4;
      logic [31:0]  got;
      axi4s_beat_t  b;
      line_no = 0;
      while ($fgets(text, fd) != 0) begin
         line_no++;
         if (text.len() >= 2 && text.substr(0, 0) != "#") begin
            cmd = text.substr(0, 0);
            fields = $sscanf(text.substr(1, text.len() - 1), "%h %h %h %h %h",
                             f0, f1, f2, f3, f4);
            if (fields == 0) begin
               stop_run($sformatf("line %0d of the input file has no values", line_no));
            end else if (cmd == "B") begin
               b        = idle_beat;
               b.tvalid = f0[0];
               b.tready = f1[0];
               b.tkeep  = f2[`DATA_BYTES-1:0];
               b.tlast  = f3[0];
               b.tuser  = f4[0];
               drive_beat(b);
            end else if (cmd == "I") begin
               idle_cycles(f0);
            end else if (cmd == "W") begin
               write_reg(f0[`REG_ADDR_W-1:0], f1);
            end else if (cmd == "R") begin
               read_reg(f0[`REG_ADDR_W-1:0], got);
               check_word(got, f1, $sformatf("register %0h", f0));
            end else if (cmd == "M") begin
               read_reg(`REG_MONITOR, got);
               check_status(line_status_t'(got[$bits(line_status_t)-1:0]),
                            line_status_t'(f0[$bits(line_status_t)-1:0]));
            end else begin
               stop_run($sformatf("unknown command %s on line %0d", cmd, line_no));
            end
         end
      end
   endtask

   initial begin
      idle_beat         = '0;
      idle_beat.aresetn = 1'b1;
      beat              = idle_beat;
      reset             = 1'b1;
      reg_wr            = 1'b0;
      reg_rd            = 1'b0;
      reg_addr          = '0;
      reg_wdata         = '0;
      repeat (5) @(posedge axi4s_if);
      reset <= 1'b0;
      fd = $fopen("tb/probe_input.txt", "r");
      if (fd == 0) begin
         stop_run("could not open tb/probe_input.txt");
      end else begin
         run_file();
         $fclose(fd);
         $display("Finished with no errors");
         $finish;
      end
   end

endmodule

// ==== tb/probe_input.txt ====
# B tvalid tready tkeep tlast tuser | I cycles | W addr data | R addr expected
# M expected {aresetn tvalid tready tlast}; all numbers hex
R 1 0
R a 0
B 1 1 ff 0 0
B 1 1 ff 0 0
B 1 1 0f 1 0
B 1 1 03 1 0
B 1 1 ff 0 0
B 1 1 01 1 0
I 8
R 1 3
R 3 1f
R 5 0
R a 7
R a 0
B 1 1 ff 0 0
B 1 0 ff 0 0
B 1 1 3f 1 1
B 1 1 07 1 1
B 1 0 01 1 0
B 0 1 ff 1 0
B 1 1 ff 1 0
I 8
R 1 4
R 3 27
R 5 2
R 7 11
W 0 1
I 4
R 1 0
R 3 0
R 5 0
R 7 0
B 1 1 ff 0 0
B 1 1 ff 1 0
B 1 1 0f 1 1
I 8
W 0 2
R 0 2
B 1 1 ff 1 0
B 1 1 ff 1 1
I 8
R 1 1
R 3 10
R 5 1
R 7 4
W 0 2
R 1 2
R 3 18
R 7 c
W 0 0
I 6
M 8
B 1 0 ff 1 0
B 1 0 ff 1 0
M d

// ==== src.f ====
+incdir+design
design/probe_pkg.sv
design/stream_counter.sv
design/probe_regmap.sv
design/stream_probe_top.sv
tb/probe_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the stream probe testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f src.f --top-module probe_tb -o probe_sim

# the simulation exits nonzero on failure, the search below decides
output="$(./obj_dir/probe_sim 2>&1)" || true
echo "$output"

if echo "$output" | grep -q "Finished with no errors"; then
   exit 0
else
   exit 1
fi
